// File: cpuPkg.sv
// phase lengths, widths, opcode enum and the instruction, phase, decode and control structs
package cpuPkg;

    // phase lengths in cycles
    localparam int unsigned FETCH_LEN  = 3;
    localparam int unsigned DECODE_LEN = 2;
    localparam int unsigned EXEC_LEN   = 1;
    localparam int unsigned CYCLE_LEN  = FETCH_LEN + DECODE_LEN + EXEC_LEN;
    localparam int unsigned DECODE_AT  = FETCH_LEN;             // first decode count
    localparam int unsigned EXEC_AT    = FETCH_LEN + DECODE_LEN; // first exec count
    localparam int unsigned PH_CNT_W   = $clog2(CYCLE_LEN);

    // widths
    localparam int unsigned INSTR_W = 16;
    localparam int unsigned DATA_W  = 8;
    localparam int unsigned ADDR_W  = 8;
    localparam int unsigned OPC_W   = 4;
    localparam int unsigned REG_W   = 2;        // register index bits
    localparam int unsigned REG_CNT = 1 << REG_W;

    typedef enum logic [OPC_W-1:0] {
        OP_LDI = 4'h0,  // rd = imm
        OP_MOV = 4'h1,  // rd = rs
        OP_ADD = 4'h2,
        OP_SUB = 4'h3,
        OP_AND = 4'h4,
        OP_XOR = 4'h5,
        OP_JMP = 4'h6,  // pc = imm
        OP_JZ  = 4'h7,  // pc = imm if zero
        OP_OUT = 4'h8,  // emit rd
        OP_NOP = 4'h9,
        OP_HLT = 4'hF
    } opcodeE;

    // instruction word with opcode in the msbs
    typedef struct packed {
        logic [OPC_W-1:0]  opcode;  // raw bits that may be unknown
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rs;
        logic [DATA_W-1:0] imm;
    } instrT;

    typedef struct packed {
        logic fetch;
        logic decode;
        logic exec;
        logic fetchStart;   // first fetch cycle
        logic decodeStart;  // first decode cycle
        logic halted;
    } phaseT;

    typedef struct packed {
        opcodeE            op;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rs;
        logic [DATA_W-1:0] imm;
        logic              writesReg;
        logic              isJump;
        logic              valid;  // clear on empty fetch slot
    } decodedT;

    typedef struct packed {
        logic              regWrite;
        opcodeE            aluOp;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rs;
        logic [DATA_W-1:0] imm;
        logic              pcLoad;
        logic              pcInc;
        logic              outEn;
    } ctrlT;

endpackage : cpuPkg

// File: phaser.sv
// phase sequencer with dead cycle, repeating fetch/decode/exec phases and halt stop
module phaser (
    input  logic          clk,
    input  logic          rst,
    input  logic          halt,
    output cpuPkg::phaseT phase
);

    logic                        live;     // low during dead cycle and after halt
    logic                        stopped;  // sticky until reset
    logic [cpuPkg::PH_CNT_W-1:0] cnt;      // position inside instruction

    always_ff @(posedge clk) begin
        if (rst) begin
            live    <= 1'b0;
            stopped <= 1'b0;
            cnt     <= '0;
        end else if (!stopped) begin
            if (!live) begin
                live <= 1'b1;               // leave dead cycle into first fetch
                cnt  <= '0;
            end else if (halt && phase.exec) begin
                live    <= 1'b0;            // freeze after this exec
                stopped <= 1'b1;
            end else if (cnt == cpuPkg::CYCLE_LEN - 1) begin
                cnt <= '0;                  // wrap to next fetch
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // phase bits straight from the counter
    always_comb begin
        phase        = '0;
        phase.halted = stopped;
        if (live) begin
            phase.fetch       = cnt < cpuPkg::DECODE_AT;
            phase.decode      = (cnt >= cpuPkg::DECODE_AT) && (cnt < cpuPkg::EXEC_AT);
            phase.exec        = (cnt >= cpuPkg::EXEC_AT) && (cnt < cpuPkg::CYCLE_LEN);
            phase.fetchStart  = cnt == 0;
            phase.decodeStart = cnt == cpuPkg::DECODE_AT;
        end
    end

    // one phase at a time while running
    assert property (@(posedge clk) disable iff (rst)
        live |-> $onehot({phase.fetch, phase.decode, phase.exec}));

    // controlGen may only request halt in exec
    assert property (@(posedge clk) disable iff (rst)
        halt |-> phase.exec);

    // decode always begins a full fetch phase later
    assert property (@(posedge clk) disable iff (rst)
        phase.fetchStart |-> ##(cpuPkg::DECODE_AT) phase.decodeStart);

endmodule : phaser

// File: instrDecoder.sv
// instruction latch during fetch and decoded-field register
module instrDecoder (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::phaseT   phase,
    input  logic            instrStrobe,
    input  cpuPkg::instrT   instrData,
    output cpuPkg::decodedT decoded
);

    cpuPkg::instrT   latched;
    logic            latchFull;  // a word arrived this fetch
    cpuPkg::decodedT decNext;

    // last strobe in the phase wins
    always_ff @(posedge clk) begin
        if (rst) begin
            latchFull <= 1'b0;
        end else if (instrStrobe) begin
            latchFull <= 1'b1;
        end else if (phase.fetchStart) begin
            latchFull <= 1'b0;        // new slot starts empty
        end
    end

    always_ff @(posedge clk) begin
        if (instrStrobe) latched <= instrData;  // word held for decode
    end

    always_comb begin
        decNext           = '0;
        decNext.op        = cpuPkg::OP_NOP;
        decNext.rd        = latched.rd;
        decNext.rs        = latched.rs;
        decNext.imm       = latched.imm;
        decNext.valid     = latchFull;
        if (latchFull) begin
            case (latched.opcode)
                cpuPkg::OP_LDI, cpuPkg::OP_MOV, cpuPkg::OP_ADD,
                cpuPkg::OP_SUB, cpuPkg::OP_AND, cpuPkg::OP_XOR: begin
                    decNext.op        = cpuPkg::opcodeE'(latched.opcode);
                    decNext.writesReg = 1'b1;
                end
                cpuPkg::OP_JMP, cpuPkg::OP_JZ: begin
                    decNext.op     = cpuPkg::opcodeE'(latched.opcode);
                    decNext.isJump = 1'b1;
                end
                cpuPkg::OP_OUT, cpuPkg::OP_NOP, cpuPkg::OP_HLT: begin
                    decNext.op = cpuPkg::opcodeE'(latched.opcode);
                end
                default: decNext.op = cpuPkg::OP_NOP;   // unknown opcode
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decoded    <= '0;
            decoded.op <= cpuPkg::OP_NOP;
        end else if (phase.decodeStart) begin
            decoded <= decNext;       // held through exec
        end
    end

    // memory answers only inside the fetch window
    assert property (@(posedge clk) disable iff (rst)
        instrStrobe |-> phase.fetch);

endmodule : instrDecoder

// File: controlGen.sv
// exec strobes, fetch request and halt from phase and decoded instruction
module controlGen (
    input  cpuPkg::phaseT   phase,
    input  cpuPkg::decodedT decoded,
    input  logic            zero,
    output cpuPkg::ctrlT    ctrl,
    output logic            fetchReq,
    output logic            halt
);

    logic isHlt;
    logic jumpTaken;

    assign fetchReq = phase.fetchStart;   // one pulse per instruction

    assign isHlt     = decoded.valid && (decoded.op == cpuPkg::OP_HLT);
    assign jumpTaken = decoded.isJump &&
                       ((decoded.op == cpuPkg::OP_JMP) || zero);   // JZ needs zero
    assign halt      = phase.exec && isHlt;

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = cpuPkg::OP_NOP;
        if (phase.exec) begin
            ctrl.aluOp = decoded.op;
            ctrl.rd    = decoded.rd;
            ctrl.rs    = decoded.rs;
            ctrl.imm   = decoded.imm;
            if (decoded.valid) begin
                ctrl.regWrite = decoded.writesReg;
                ctrl.outEn    = decoded.op == cpuPkg::OP_OUT;
                ctrl.pcLoad   = jumpTaken;
            end
            // step unless jumping or parked on the HLT word
            ctrl.pcInc = !ctrl.pcLoad && !isHlt;
        end
    end

endmodule : controlGen

// File: dataPath.sv
// four-register file, ALU, zero flag, program counter and output register
module dataPath (
    input  logic                      clk,
    input  logic                      rst,
    input  cpuPkg::ctrlT              ctrl,
    output logic [cpuPkg::ADDR_W-1:0] pc,
    output logic [cpuPkg::DATA_W-1:0] outData,
    output logic                      zero,
    output logic                      outStrobe
);

    logic [cpuPkg::DATA_W-1:0] regFile [cpuPkg::REG_CNT];
    logic [cpuPkg::DATA_W-1:0] opA;     // rd operand
    logic [cpuPkg::DATA_W-1:0] opB;     // rs operand
    logic [cpuPkg::DATA_W-1:0] aluRes;

    assign opA = regFile[ctrl.rd];
    assign opB = regFile[ctrl.rs];

    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::OP_LDI: aluRes = ctrl.imm;
            cpuPkg::OP_MOV: aluRes = opB;
            cpuPkg::OP_ADD: aluRes = opA + opB;     // wraps without carry
            cpuPkg::OP_SUB: aluRes = opA - opB;
            cpuPkg::OP_AND: aluRes = opA & opB;
            cpuPkg::OP_XOR: aluRes = opA ^ opB;
            default:        aluRes = opA;
        endcase
    end

    // registers and zero flag
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::REG_CNT; i++) begin
                regFile[i] <= '0;
            end
            zero <= 1'b0;
        end else if (ctrl.regWrite) begin
            regFile[ctrl.rd] <= aluRes;
            zero             <= aluRes == '0;   // any write updates the flag
        end
    end

    // program counter wraps modulo 256
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (ctrl.pcLoad) begin
            pc <= ctrl.imm;
        end else if (ctrl.pcInc) begin
            pc <= pc + 1'b1;
        end
    end

    // output strobe lands one cycle after exec
    always_ff @(posedge clk) begin
        if (rst) begin
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= ctrl.outEn;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.outEn) outData <= opA;     // emitted register value
    end

    assert property (@(posedge clk) disable iff (rst)
        !(ctrl.pcLoad && ctrl.pcInc));

endmodule : dataPath

// File: cpuCore.sv
// top level joining phaser, instruction decoder, control generator and data path
module cpuCore (
    input  logic                      clk,
    input  logic                      rst,
    output logic                      fetchReq,
    output logic [cpuPkg::ADDR_W-1:0] fetchAddr,
    input  logic                      instrStrobe,
    input  cpuPkg::instrT             instrData,
    output logic                      outStrobe,
    output logic [cpuPkg::DATA_W-1:0] outData,
    output logic                      halted
);

    cpuPkg::phaseT   phase;     // when
    cpuPkg::decodedT decoded;   // what
    cpuPkg::ctrlT    ctrl;
    logic            zero;
    logic            halt;

    phaser uPhaser (
        .clk   (clk),
        .rst   (rst),
        .halt  (halt),
        .phase (phase)
    );

    instrDecoder uDecoder (
        .clk         (clk),
        .rst         (rst),
        .phase       (phase),
        .instrStrobe (instrStrobe),
        .instrData   (instrData),
        .decoded     (decoded)
    );

    controlGen uCtrl (
        .phase    (phase),
        .decoded  (decoded),
        .zero     (zero),
        .ctrl     (ctrl),
        .fetchReq (fetchReq),
        .halt     (halt)
    );

    dataPath uData (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .pc        (fetchAddr),  // pc doubles as fetch address
        .outData   (outData),
        .zero      (zero),
        .outStrobe (outStrobe)
    );

    assign halted = phase.halted;

endmodule : cpuCore

// File: tbCpuCore.sv
// testbench with program-memory model, fetch and output checker and watchdog for cpuCore
module tbCpuCore;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD   = 4;
    localparam int RST_CYC  = 5;
    localparam int HOLD_CYC = 12;   // cycles watched after halt
    localparam int INSTR_CYC = 6;   // fetchReq to fetchReq
    localparam int STIM_LEN = 256;

    logic                      clk;
    logic                      rst;
    logic                      fetchReq;
    logic [cpuPkg::ADDR_W-1:0] fetchAddr;
    logic                      instrStrobe;
    cpuPkg::instrT             instrData;
    logic                      outStrobe;
    logic [cpuPkg::DATA_W-1:0] outData;
    logic                      halted;

    logic [15:0]   stim [STIM_LEN];   // raw file contents
    cpuPkg::instrT progMem [256];
    logic [7:0]    expOut [$];        // bytes still expected in order
    logic [15:0]   lfsr;
    int            limitNs = 0;

    cpuCore u_dut (
        .clk         (clk),
        .rst         (rst),
        .fetchReq    (fetchReq),
        .fetchAddr   (fetchAddr),
        .instrStrobe (instrStrobe),
        .instrData   (instrData),
        .outStrobe   (outStrobe),
        .outData     (outData),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // reset pulse then answer fetches until halt
    task automatic runProgram(input logic [7:0] finalPc);
        int         sinceRst;
        int         sinceFetch;
        bit         seenFetch;
        bit         skipped;
        bit         answer;
        logic [7:0] lastAddr;
        @(posedge clk);
        #1;
        rst         = 1'b1;
        instrStrobe = 1'b0;
        repeat (RST_CYC) @(posedge clk);
        check("fetchReq", fetchReq, 0);     // core held in reset
        check("outStrobe", outStrobe, 0);
        check("halted", halted, 0);
        check("fetchAddr", fetchAddr, 0);
        #1;
        rst        = 1'b0;
        sinceRst   = 0;
        sinceFetch = 0;
        seenFetch  = 1'b0;
        skipped    = 1'b0;
        lastAddr   = '0;
        while (!halted) begin
            @(posedge clk);
            sinceRst++;
            sinceFetch++;
            answer = 1'b0;
            if (outStrobe) begin
                if (expOut.size() == 0) begin
                    failRun("output byte appeared that the program does not emit");
                end else begin
                    check("outData", outData, expOut.pop_front());
                end
            end
            if (fetchReq) begin
                if (!seenFetch) begin
                    check("fetchDelay", sinceRst, 2);   // dead cycle first
                    check("fetchAddr", fetchAddr, 0);
                end else begin
                    check("fetchGap", sinceFetch, INSTR_CYC);
                end
                if (skipped) begin
                    check("fetchAddr", fetchAddr, 8'(lastAddr + 1));  // empty slot steps pc
                end
                lastAddr = fetchAddr;
                skipped  = 1'b0;
                if (progMem[fetchAddr].opcode == cpuPkg::OP_NOP) begin
                    skipped = lfsr[0];                  // one bit per nop slot
                    lfsr    = lfsrNext(lfsr);
                end
                seenFetch  = 1'b1;
                sinceFetch = 0;
                answer     = !skipped;
            end
            #1;
            instrStrobe = answer;                     // one cycle after fetchReq
            instrData   = progMem[lastAddr];
        end
        repeat (HOLD_CYC) begin
            @(posedge clk);
            check("fetchReq", fetchReq, 0);
            check("outStrobe", outStrobe, 0);
            check("halted", halted, 1);
            check("fetchAddr", fetchAddr, finalPc);
        end
        check("outputsLeft", expOut.size(), 0);
    endtask

    initial begin
        wait (limitNs > 0);
        #(limitNs);
        failRun("timeout: the core did not halt within the expected time");
    end

    initial begin
        int ptr;
        int progCnt;
        int totalWords;
        int words;
        int outCnt;
        rst         = 1'b1;
        instrStrobe = 1'b0;
        instrData   = '0;
        lfsr        = 16'd65;
        $readmemh("cpuCoreStimulus.txt", stim);
        progCnt = stim[0];
        if (progCnt == 0) begin
            failRun("stimulus file holds no programs");
        end
        // first pass only sizes the watchdog
        ptr        = 1;
        totalWords = 0;
        for (int p = 0; p < progCnt; p++) begin
            totalWords += stim[ptr];
            ptr        += stim[ptr] + 1;
            ptr        += stim[ptr] + 2;       // outputs plus final pc
        end
        limitNs = (INSTR_CYC * totalWords * 2 + progCnt * (RST_CYC + HOLD_CYC + 4)) * PERIOD;
        ptr = 1;
        for (int p = 0; p < progCnt; p++) begin
            for (int a = 0; a < 256; a++) begin
                progMem[a] = {cpuPkg::OP_HLT, 4'h0, 8'(a)};  // runaway pc lands on HLT
            end
            words = stim[ptr];
            ptr++;
            for (int a = 0; a < words; a++) begin
                progMem[a] = stim[ptr + a];
            end
            ptr += words;
            outCnt = stim[ptr];
            expOut.delete();
            for (int i = 0; i < outCnt; i++) begin
                expOut.push_back(stim[ptr + 1 + i][7:0]);
            end
            ptr += outCnt + 1;
            $display("program %0d: %0d words, %0d output bytes", p, words, outCnt);
            runProgram(stim[ptr][7:0]);
            ptr++;
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule : tbCpuCore

// File: cpuCoreStimulus.txt
// program count, then per program: word count, words (opcode rd rs imm),
// output count with expected bytes in order, final fetchAddr at halt
0003
// alu and register moves, nop at 7
000D
0035 040A 2100 8000 1800 3900 8800 9000
4900 5100 8000 8800 F000
0004 003F 0035 0035 0000
000C
// jz not taken, jmp, jz taken
000F
0C07 7005 8C00 6006 8C00 F000 9000 5F00
700B 8C00 F000 045A 8400 9000 F000
0002 0007 005A
000E
// add wraps, jmp past the program into the halt fill
0006
9000 08C3 9000 2A00 8800 6020
0001 0086
0020

// File: cpuCore.f
cpuPkg.sv
phaser.sv
instrDecoder.sv
controlGen.sv
dataPath.sv
cpuCore.sv
tbCpuCore.sv

// File: Bender.yml
package:
  name: cpuCore

sources:
  - cpuPkg.sv
  - phaser.sv
  - instrDecoder.sv
  - controlGen.sv
  - dataPath.sv
  - cpuCore.sv
  - target: test
    files:
      - tbCpuCore.sv
